//--- pcnn_core.f
pcnn_cfg_pkg.sv
pcnn_isa_pkg.sv
glb.sv
gic.sv
ccu.sv
pcnn_core.sv
tb_checker.sv
tb_pcnn_core.sv

//--- tb_pcnn_core.sv
`timescale 1ns/1ps

module tb_pcnn_core
    import pcnn_cfg_pkg::*;
    import pcnn_isa_pkg::*;
();

    localparam int NUM_ROWS = 12;

    logic                  clk;
    logic                  reset_i;
    logic [PORT_WIDTH-1:0] in_dat_i;
    logic                  in_isa_i;
    logic                  in_vld_i;
    logic                  in_rdy_o;
    logic [PORT_WIDTH-1:0] out_dat_o;
    logic                  out_vld_o;
    logic                  out_last_o;
    logic                  out_rdy_i;
    logic                  cmd_vld_o;
    int                    val_err_cnt;
    int                    proto_err_cnt;

    // Stimulus table, one instruction per row
    isa_word_u   tbl_word [NUM_ROWS];
    int          tbl_duty [NUM_ROWS];
    logic [31:0] rng;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    pcnn_core #(
        .ADDR_WIDTH (DEF_ADDR_WIDTH),
        .NUM_BANK   (DEF_NUM_BANK),
        .SRAM_WORD  (DEF_SRAM_WORD)
    ) dut0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_dat_i   (in_dat_i),
        .in_isa_i   (in_isa_i),
        .in_vld_i   (in_vld_i),
        .in_rdy_o   (in_rdy_o),
        .out_dat_o  (out_dat_o),
        .out_vld_o  (out_vld_o),
        .out_last_o (out_last_o),
        .out_rdy_i  (out_rdy_i),
        .cmd_vld_o  (cmd_vld_o)
    );

    tb_checker #(
        .NUM_BANK  (DEF_NUM_BANK),
        .SRAM_WORD (DEF_SRAM_WORD)
    ) chk0 (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_dat_i        (in_dat_i),
        .in_isa_i        (in_isa_i),
        .in_vld_i        (in_vld_i),
        .in_rdy_o        (in_rdy_o),
        .out_dat_o       (out_dat_o),
        .out_vld_o       (out_vld_o),
        .out_last_o      (out_last_o),
        .out_rdy_i       (out_rdy_i),
        .cmd_vld_o       (cmd_vld_o),
        .val_err_cnt_o   (val_err_cnt),
        .proto_err_cnt_o (proto_err_cnt)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic set_row(input int idx, input logic [3:0] opc, input logic [15:0] addr,
                           input logic [11:0] len, input int duty);
        isa_word_u w;
        w.xfer.addr   = addr;
        w.xfer.len    = len;
        w.hdr.opc     = opc;
        tbl_word[idx] = w;
        tbl_duty[idx] = duty;
    endtask

    // Hold a beat from the falling edge until the core takes it
    task automatic send_beat(input logic is_isa, input logic [PORT_WIDTH-1:0] dat);
        @(negedge clk);
        in_isa_i = is_isa;
        in_dat_i = dat;
        in_vld_i = 1'b1;
        @(posedge clk);
        while (!in_rdy_o) @(posedge clk);
    endtask

    task automatic drain_store(input int duty);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            in_vld_i  = 1'b0;
            rng       = lcg_next(rng);
            out_rdy_i = (rng[23:8] % 100) < duty;
            @(posedge clk);
            done = out_vld_o && out_rdy_i && out_last_o;
        end
        @(negedge clk);
        out_rdy_i = 1'b1;
    endtask

    task automatic apply_row(input isa_word_u w, input int duty);
        send_beat(1'b1, w);
        if (w.hdr.opc == OPC_LOAD) begin
            for (int k = 0; k <= int'(w.xfer.len); k++) begin
                rng = lcg_next(rng);
                send_beat(1'b0, rng);
            end
        end else if (w.hdr.opc == OPC_STORE) begin
            drain_store(duty);
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        int total;
        clk       = 1'b0;
        reset_i   = 1'b1;
        in_dat_i  = '0;
        in_isa_i  = 1'b1;
        in_vld_i  = 1'b0;
        out_rdy_i = 1'b1;
        rng       = 32'h3e8b_b9e8;

        // Crossing banks, wrap at the top, mid-range reads, stalls
        set_row(0,  4'd1, 16'h0000, 12'd15, 100);
        set_row(1,  4'd2, 16'h0000, 12'd15, 100);
        set_row(2,  4'd1, 16'h03fd, 12'd9,  100);
        set_row(3,  4'd2, 16'h03fd, 12'd9,  100);
        set_row(4,  4'd2, 16'h0005, 12'd7,  50);
        set_row(5,  4'd7, 16'h0000, 12'd3,  100);
        set_row(6,  4'd1, 16'h0206, 12'd31, 100);
        set_row(7,  4'd2, 16'h0206, 12'd31, 30);
        set_row(8,  4'd2, 16'h0210, 12'd4,  60);
        set_row(9,  4'd1, 16'h0400, 12'd3,  100);
        set_row(10, 4'd2, 16'h0000, 12'd15, 70);
        set_row(11, 4'd2, 16'h83ff, 12'd1,  100);

        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += 1;
            if (tbl_word[i].hdr.opc == OPC_LOAD || tbl_word[i].hdr.opc == OPC_STORE) begin
                total += int'(tbl_word[i].xfer.len) + 1;
            end
        end
        cycle_limit = 8 * total + 200;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(tbl_word[i], tbl_duty[i]);
        end

        // Quiet tail, any stray output is caught by the checker
        repeat (10) @(negedge clk);
        $display("Errors: %0d value, %0d protocol", val_err_cnt, proto_err_cnt);
        if (val_err_cnt == 0 && proto_err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Run stopped after %0d cycles, the core stopped responding", cycle_cnt);
            $display("Errors: %0d value, %0d protocol", val_err_cnt, proto_err_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker
    import pcnn_cfg_pkg::*;
    import pcnn_isa_pkg::*;
#(
    parameter int NUM_BANK  = DEF_NUM_BANK,
    parameter int SRAM_WORD = DEF_SRAM_WORD
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [PORT_WIDTH-1:0] in_dat_i,
    input  logic                  in_isa_i,
    input  logic                  in_vld_i,
    input  logic                  in_rdy_o,
    input  logic [PORT_WIDTH-1:0] out_dat_o,
    input  logic                  out_vld_o,
    input  logic                  out_last_o,
    input  logic                  out_rdy_i,
    input  logic                  cmd_vld_o,
    output int                    val_err_cnt_o,
    output int                    proto_err_cnt_o
);

    localparam int DEPTH = NUM_BANK * SRAM_WORD;

    logic [PORT_WIDTH-1:0] model_mem [DEPTH];
    isa_word_u             isa_word;
    int                    load_addr     = 0;
    int                    store_addr    = 0;
    int                    store_left    = 0;
    logic                  store_act     = 1'b0;
    logic                  cmd_seen      = 1'b0;
    logic                  reset_q       = 1'b1;

    initial begin
        val_err_cnt_o   = 0;
        proto_err_cnt_o = 0;
    end

    // ==========================================================
    // Sampled on the rising edge, inputs settle at the falling one
    // ==========================================================

    always @(posedge clk) begin
        isa_word = in_dat_i;
        if (reset_i) begin
            store_act = 1'b0;
            cmd_seen  = 1'b0;
            load_addr = 0;
        end else begin
            if (reset_q && in_isa_i && !in_rdy_o) begin
                $display("in_rdy_o is low for an instruction beat right after reset");
                proto_err_cnt_o++;
            end
            // One pulse per store, never outside a store
            if (cmd_vld_o) begin
                if (!store_act || cmd_seen) begin
                    $display("Unexpected cmd_vld_o pulse at %0t", $time);
                    proto_err_cnt_o++;
                end
                cmd_seen = 1'b1;
            end
            if (out_vld_o && !store_act) begin
                $display("Output word offered with no store in progress at %0t", $time);
                proto_err_cnt_o++;
            end else if (out_vld_o && out_rdy_i) begin
                if (!cmd_seen) begin
                    $display("Output word arrived before its cmd_vld_o pulse at %0t", $time);
                    proto_err_cnt_o++;
                end
                if (out_dat_o !== model_mem[store_addr]) begin
                    $display("error out_dat_o expected %h actual %h",
                             model_mem[store_addr], out_dat_o);
                    val_err_cnt_o++;
                end
                if (out_last_o !== (store_left == 1)) begin
                    $display("error out_last_o expected %h actual %h",
                             (store_left == 1), out_last_o);
                    val_err_cnt_o++;
                end
                store_addr = (store_addr + 1) % DEPTH;
                store_left--;
                if (store_left == 0) begin
                    store_act = 1'b0;
                    cmd_seen  = 1'b0;
                end
            end
            // Track instructions and load beats taken by the core
            if (in_vld_i && in_rdy_o) begin
                if (!in_isa_i) begin
                    model_mem[load_addr] = in_dat_i;
                    load_addr = (load_addr + 1) % DEPTH;
                end else if (isa_word.hdr.opc == OPC_LOAD) begin
                    load_addr = int'(isa_word.xfer.addr) % DEPTH;
                end else if (isa_word.hdr.opc == OPC_STORE) begin
                    store_addr = int'(isa_word.xfer.addr) % DEPTH;
                    store_left = int'(isa_word.xfer.len) + 1;
                    store_act  = 1'b1;
                    cmd_seen   = 1'b0;
                end
            end
        end
        reset_q = reset_i;
    end

endmodule

//--- pcnn_core.sv
`timescale 1ns/1ps

module pcnn_core
    import pcnn_cfg_pkg::*;
    import pcnn_isa_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int SRAM_WORD  = DEF_SRAM_WORD
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [PORT_WIDTH-1:0] in_dat_i,
    input  logic                  in_isa_i,
    input  logic                  in_vld_i,
    output logic                  in_rdy_o,
    output logic [PORT_WIDTH-1:0] out_dat_o,
    output logic                  out_vld_o,
    output logic                  out_last_o,
    input  logic                  out_rdy_i,
    output logic                  cmd_vld_o
);

    // ccu to gic
    logic                  cfg_vld;
    logic                  cfg_rdy;
    isa_word_u             cfg_word;
    logic [PORT_WIDTH-1:0] dat;
    logic                  dat_vld;
    logic                  dat_rdy;

    // gic to glb
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [PORT_WIDTH-1:0] wr_dat;
    logic                  wr_vld;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  rd_addr_vld;
    logic                  rd_addr_rdy;
    logic [PORT_WIDTH-1:0] rd_dat;
    logic                  rd_dat_vld;
    logic                  rd_dat_rdy;

    // ==========================================================
    // Control, transfer engine, buffer
    // ==========================================================

    ccu u_ccu (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_dat_i   (in_dat_i),
        .in_isa_i   (in_isa_i),
        .in_vld_i   (in_vld_i),
        .in_rdy_o   (in_rdy_o),
        .cfg_vld_o  (cfg_vld),
        .cfg_word_o (cfg_word),
        .cfg_rdy_i  (cfg_rdy),
        .dat_o      (dat),
        .dat_vld_o  (dat_vld),
        .dat_rdy_i  (dat_rdy)
    );

    gic #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .NUM_BANK   (NUM_BANK),
        .SRAM_WORD  (SRAM_WORD)
    ) u_gic (
        .clk           (clk),
        .reset_i       (reset_i),
        .cfg_vld_i     (cfg_vld),
        .cfg_word_i    (cfg_word),
        .cfg_rdy_o     (cfg_rdy),
        .dat_i         (dat),
        .dat_vld_i     (dat_vld),
        .dat_rdy_o     (dat_rdy),
        .cmd_vld_o     (cmd_vld_o),
        .out_dat_o     (out_dat_o),
        .out_vld_o     (out_vld_o),
        .out_last_o    (out_last_o),
        .out_rdy_i     (out_rdy_i),
        .wr_addr_o     (wr_addr),
        .wr_dat_o      (wr_dat),
        .wr_vld_o      (wr_vld),
        .rd_addr_o     (rd_addr),
        .rd_addr_vld_o (rd_addr_vld),
        .rd_addr_rdy_i (rd_addr_rdy),
        .rd_dat_i      (rd_dat),
        .rd_dat_vld_i  (rd_dat_vld),
        .rd_dat_rdy_o  (rd_dat_rdy)
    );

    // Write port never stalls, so its ready is left open
    glb #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .NUM_BANK   (NUM_BANK),
        .SRAM_WORD  (SRAM_WORD)
    ) u_glb (
        .clk           (clk),
        .reset_i       (reset_i),
        .wr_addr_i     (wr_addr),
        .wr_dat_i      (wr_dat),
        .wr_vld_i      (wr_vld),
        .wr_rdy_o      (),
        .rd_addr_i     (rd_addr),
        .rd_addr_vld_i (rd_addr_vld),
        .rd_addr_rdy_o (rd_addr_rdy),
        .rd_dat_o      (rd_dat),
        .rd_dat_vld_o  (rd_dat_vld),
        .rd_dat_rdy_i  (rd_dat_rdy)
    );

endmodule

//--- ccu.sv
`timescale 1ns/1ps

module ccu
    import pcnn_cfg_pkg::*;
    import pcnn_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [PORT_WIDTH-1:0] in_dat_i,
    input  logic                  in_isa_i,
    input  logic                  in_vld_i,
    output logic                  in_rdy_o,
    output logic                  cfg_vld_o,
    output isa_word_u             cfg_word_o,
    input  logic                  cfg_rdy_i,
    output logic [PORT_WIDTH-1:0] dat_o,
    output logic                  dat_vld_o,
    input  logic                  dat_rdy_i
);

    isa_word_u isa_q;
    logic      hold_q;
    logic      isa_fire;
    logic      isa_known;
    logic      isa_done;

    // ==========================================================
    // Instruction intake
    // ==========================================================

    // One instruction held at a time
    assign isa_fire = in_vld_i && in_isa_i && !hold_q;

    always_ff @(posedge clk) begin
        if (isa_fire) begin
            isa_q <= in_dat_i;
        end
    end

    // Decode through the raw header
    assign isa_known = (isa_q.hdr.opc == OPC_LOAD) || (isa_q.hdr.opc == OPC_STORE);

    // Known words leave on dispatch, unknown ones are dropped at once
    assign isa_done = (cfg_vld_o && cfg_rdy_i) || (hold_q && !isa_known);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_q <= 1'b0;
        end else if (isa_fire) begin
            hold_q <= 1'b1;
        end else if (isa_done) begin
            hold_q <= 1'b0;
        end
    end

    assign cfg_vld_o  = hold_q && isa_known;
    assign cfg_word_o = isa_q;

    // ==========================================================
    // Beat steering
    // ==========================================================

    // Data beats go straight to gic
    assign dat_o     = in_dat_i;
    assign dat_vld_o = in_vld_i && !in_isa_i;
    assign in_rdy_o  = in_isa_i ? !hold_q : dat_rdy_i;

endmodule

//--- gic.sv
`timescale 1ns/1ps

module gic
    import pcnn_cfg_pkg::*;
    import pcnn_isa_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int SRAM_WORD  = DEF_SRAM_WORD
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  cfg_vld_i,
    input  isa_word_u             cfg_word_i,
    output logic                  cfg_rdy_o,
    input  logic [PORT_WIDTH-1:0] dat_i,
    input  logic                  dat_vld_i,
    output logic                  dat_rdy_o,
    output logic                  cmd_vld_o,
    output logic [PORT_WIDTH-1:0] out_dat_o,
    output logic                  out_vld_o,
    output logic                  out_last_o,
    input  logic                  out_rdy_i,
    output logic [ADDR_WIDTH-1:0] wr_addr_o,
    output logic [PORT_WIDTH-1:0] wr_dat_o,
    output logic                  wr_vld_o,
    output logic [ADDR_WIDTH-1:0] rd_addr_o,
    output logic                  rd_addr_vld_o,
    input  logic                  rd_addr_rdy_i,
    input  logic [PORT_WIDTH-1:0] rd_dat_i,
    input  logic                  rd_dat_vld_i,
    output logic                  rd_dat_rdy_o
);

    localparam int DEPTH     = NUM_BANK * SRAM_WORD;
    localparam int CNT_WIDTH = ISA_LEN_WIDTH + 1;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_LOAD  = 2'd1;
    localparam logic [1:0] ST_STORE = 2'd2;

    logic [1:0]            state_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH-1:0] addr_nxt;
    logic [ADDR_WIDTH-1:0] start_addr;
    logic [CNT_WIDTH-1:0]  len_q;
    logic [CNT_WIDTH-1:0]  rem_q;
    logic [CNT_WIDTH-1:0]  ret_cnt_q;
    logic [CNT_WIDTH-1:0]  req_cnt;
    logic [CNT_WIDTH-1:0]  in_flight;
    logic [CNT_WIDTH-1:0]  xfer_cnt;
    logic                  cmd_q;
    logic                  cfg_fire;
    logic                  dat_fire;
    logic                  rd_fire;
    logic                  out_fire;

    assign cfg_rdy_o  = (state_q == ST_IDLE);
    assign cfg_fire   = cfg_vld_i && cfg_rdy_o;
    assign start_addr = ADDR_WIDTH'(cfg_word_i.xfer.addr % DEPTH);
    assign xfer_cnt   = {1'b0, cfg_word_i.xfer.len} + 1'b1;
    // Address wraps at the end of the buffer
    assign addr_nxt   = (addr_q == ADDR_WIDTH'(DEPTH - 1)) ? '0 : addr_q + 1'b1;

    // Load path, one buffer write per accepted beat
    assign dat_rdy_o = (state_q == ST_LOAD);
    assign dat_fire  = dat_vld_i && dat_rdy_o;
    assign wr_addr_o = addr_q;
    assign wr_dat_o  = dat_i;
    assign wr_vld_o  = dat_fire;

    // Store path, at most two reads outstanding
    assign req_cnt       = len_q - rem_q;
    assign in_flight     = req_cnt - ret_cnt_q;
    assign rd_addr_o     = addr_q;
    assign rd_addr_vld_o = (state_q == ST_STORE) && (rem_q != '0) && (in_flight < 2);
    assign rd_fire       = rd_addr_vld_o && rd_addr_rdy_i;

    assign out_dat_o    = rd_dat_i;
    assign out_vld_o    = rd_dat_vld_i;
    assign out_last_o   = rd_dat_vld_i && ((ret_cnt_q + 1'b1) == len_q);
    assign rd_dat_rdy_o = out_rdy_i;
    assign out_fire     = out_vld_o && out_rdy_i;
    assign cmd_vld_o    = cmd_q;

    // ==========================================================
    // Transfer FSM and counters
    // ==========================================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= ST_IDLE;
            cmd_q     <= 1'b0;
            addr_q    <= '0;
            len_q     <= '0;
            rem_q     <= '0;
            ret_cnt_q <= '0;
        end else begin
            cmd_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (cfg_fire && (cfg_word_i.xfer.opc == OPC_STORE)) begin
                        state_q <= ST_STORE;
                        cmd_q   <= 1'b1;
                    end else if (cfg_fire && (cfg_word_i.xfer.opc == OPC_LOAD)) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (dat_fire && (rem_q == CNT_WIDTH'(1))) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_STORE: begin
                    if (out_fire && out_last_o) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase

            if (cfg_fire) begin
                addr_q    <= start_addr;
                len_q     <= xfer_cnt;
                rem_q     <= xfer_cnt;
                ret_cnt_q <= '0;
            end else begin
                // Write beat or read request moves the address
                if (dat_fire || rd_fire) begin
                    addr_q <= addr_nxt;
                    rem_q  <= rem_q - 1'b1;
                end
                if (out_fire) begin
                    ret_cnt_q <= ret_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

//--- glb.sv
`timescale 1ns/1ps

module glb
    import pcnn_cfg_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int NUM_BANK   = DEF_NUM_BANK,
    parameter int SRAM_WORD  = DEF_SRAM_WORD
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [PORT_WIDTH-1:0] wr_dat_i,
    input  logic                  wr_vld_i,
    output logic                  wr_rdy_o,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    input  logic                  rd_addr_vld_i,
    output logic                  rd_addr_rdy_o,
    output logic [PORT_WIDTH-1:0] rd_dat_o,
    output logic                  rd_dat_vld_o,
    input  logic                  rd_dat_rdy_i
);

    localparam int BANK_BITS = $clog2(NUM_BANK);
    localparam int ROW_BITS  = $clog2(SRAM_WORD);

    logic [BANK_BITS-1:0] wr_bank;
    logic [BANK_BITS-1:0] rd_bank;
    logic [ROW_BITS-1:0]  wr_row;
    logic [ROW_BITS-1:0]  rd_row;
    logic                 bank_hit;
    logic                 rd_fire;
    logic                 rd_pop;
    logic [PORT_WIDTH-1:0] bank_rd [NUM_BANK];
    logic [PORT_WIDTH-1:0] skid_q [2];
    logic                 wr_ptr_q;
    logic                 rd_ptr_q;
    logic [1:0]           cnt_q;

    // Low bits pick the bank, the rest pick the row
    assign wr_bank = wr_addr_i[BANK_BITS-1:0];
    assign wr_row  = wr_addr_i[BANK_BITS +: ROW_BITS];
    assign rd_bank = rd_addr_i[BANK_BITS-1:0];
    assign rd_row  = rd_addr_i[BANK_BITS +: ROW_BITS];

    // ==========================================================
    // Bank arrays
    // ==========================================================

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        logic [PORT_WIDTH-1:0] ram [SRAM_WORD];

        always_ff @(posedge clk) begin
            if (wr_vld_i && (wr_bank == BANK_BITS'(b))) begin
                ram[wr_row] <= wr_dat_i;
            end
        end

        assign bank_rd[b] = ram[rd_row];
    end

    // Writes never stall
    assign wr_rdy_o = 1'b1;

    // Write wins a bank conflict, read waits a cycle
    assign bank_hit      = wr_vld_i && (wr_bank == rd_bank);
    assign rd_addr_rdy_o = !bank_hit && ((cnt_q != 2'd2) || rd_dat_rdy_i);
    assign rd_fire       = rd_addr_vld_i && rd_addr_rdy_o;

    // ==========================================================
    // Two-entry output skid buffer
    // ==========================================================

    assign rd_dat_vld_o = (cnt_q != 2'd0);
    assign rd_dat_o     = skid_q[rd_ptr_q];
    assign rd_pop       = rd_dat_vld_o && rd_dat_rdy_i;

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            skid_q[wr_ptr_q] <= bank_rd[rd_bank];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (rd_fire) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (rd_pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            case ({rd_fire, rd_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

//--- pcnn_isa_pkg.sv
package pcnn_isa_pkg;

    // ==========================================================
    // Instruction field widths
    // ==========================================================

    localparam int OPC_WIDTH      = 4;
    localparam int ISA_ADDR_WIDTH = 16;
    localparam int ISA_LEN_WIDTH  = 12;

    // Opcodes handled by the core, all other codes are skipped
    typedef enum logic [OPC_WIDTH-1:0] {
        OPC_LOAD  = 4'd1,
        OPC_STORE = 4'd2
    } opcode_e;

    // Raw view, opcode in the top bits
    typedef struct packed {
        logic [OPC_WIDTH-1:0]                    opc;
        logic [ISA_ADDR_WIDTH+ISA_LEN_WIDTH-1:0] payload;
    } isa_hdr_s;

    // Transfer view, word count is len + 1
    typedef struct packed {
        opcode_e                   opc;
        logic [ISA_ADDR_WIDTH-1:0] addr;
        logic [ISA_LEN_WIDTH-1:0]  len;
    } isa_xfer_s;

    typedef union packed {
        isa_hdr_s  hdr;
        isa_xfer_s xfer;
    } isa_word_u;

endpackage

//--- pcnn_cfg_pkg.sv
package pcnn_cfg_pkg;

    // ==========================================================
    // Datapath width
    // ==========================================================

    // Host stream word and buffer word are the same size
    localparam int PORT_WIDTH = 32;

    // ==========================================================
    // Global buffer geometry defaults
    // ==========================================================

    // Word address into the whole buffer
    localparam int DEF_ADDR_WIDTH = 10;

    // Banks are interleaved on the low address bits, keep a power of two
    localparam int DEF_NUM_BANK = 4;

    // Rows in each bank
    localparam int DEF_SRAM_WORD = 256;

endpackage
